//--- Makefile
TOP = tb_spi_reg_bridge
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f spi_reg_bridge.f

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "^NO ERRORS$$" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

lint:
	verilator --lint-only --timing -Wall --top-module spi_reg_bridge -f spi_reg_bridge.f

clean:
	rm -rf obj_dir $(LOG)

//--- spi_cmd_decoder.sv
// spi frame tracker
// command byte latch, register write on second byte, read data for miso
`timescale 1ns/1ps

module spi_cmd_decoder #(
	parameter int NUM_REGS = spi_reg_pkg::num_regs
) (
	input  logic                            sys_clk,
	input  logic                            sys_rst_n,
	input  logic                            cs_fall,	// frame start
	input  logic                            byte_ack,
	input  logic [spi_reg_pkg::byte_w-1:0]  rx_byte,
	input  logic [spi_reg_pkg::byte_w-1:0]  spi_rdata,	// comb read of spi_addr
	output logic [spi_reg_pkg::byte_w-1:0]  tx_byte,
	output logic                            spi_we,
	output logic [spi_reg_pkg::addr_w-1:0]  spi_addr,
	output logic [spi_reg_pkg::byte_w-1:0]  spi_wdata
);

	logic [1:0] byte_idx;	// 0 cmd, 1 data, 2 extra bytes ignored
	logic       rd_flag;	// current frame is a read
	logic       addr_ok;	// address inside the bank
	logic       wr_fire;

	assign addr_ok = int'(spi_addr) < NUM_REGS;

	// write only on the data byte of a write frame
	assign wr_fire = byte_ack && byte_idx == 2'd1 && !rd_flag && addr_ok;

	// data byte of a read frame carries the register, all else zero
	assign tx_byte = (rd_flag && byte_idx == 2'd1 && !cs_fall) ? spi_rdata : '0;

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			byte_idx <= 2'd0;
			rd_flag  <= 1'b0;
			spi_addr <= '0;
		end else if (cs_fall) begin
			byte_idx <= 2'd0;	// new frame
			rd_flag  <= 1'b0;
		end else if (byte_ack && byte_idx == 2'd0) begin
			byte_idx <= 2'd1;
			rd_flag  <= rx_byte[spi_reg_pkg::cmd_read_bit];
			spi_addr <= rx_byte[spi_reg_pkg::addr_w-1:0];
		end else if (byte_ack && byte_idx == 2'd1) begin
			byte_idx <= 2'd2;	// saturate, later bytes dropped
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			spi_we <= 1'b0;
		else
			spi_we <= wr_fire;	// one cycle after the data ack
	end

	always_ff @(posedge sys_clk) begin
		if (wr_fire)
			spi_wdata <= rx_byte;
	end

	a_we_in_range: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		spi_we |-> int'(spi_addr) < NUM_REGS);

endmodule

//--- spi_edge_sync.sv
// two-flop synchronizers for cs, sclk and mosi
// cs edge pulses and sclk lead/trail phase pulses per spi mode
`timescale 1ns/1ps

module spi_edge_sync #(
	parameter bit CPOL = 1'b1,	// sclk idle level
	parameter bit CPHA = 1'b1	// 1 = sample on trailing edge
) (
	input  logic sys_clk,
	input  logic sys_rst_n,
	input  logic cs,
	input  logic sclk,
	input  logic mosi,
	output logic cs_sync,
	output logic cs_fall,
	output logic cs_rise,
	output logic sclk_lead,
	output logic sclk_trail,
	output logic mosi_sync
);

	logic [1:0] cs_ff;	// sync chain, [1] is the stable copy
	logic [1:0] sclk_ff;
	logic [1:0] mosi_ff;
	logic       cs_prev;	// one cycle older copy for edges
	logic       sclk_prev;
	logic       sclk_rise;
	logic       sclk_fall;
	logic       sample_pulse;

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			cs_ff     <= 2'b11;	// deselected
			cs_prev   <= 1'b1;
			sclk_ff   <= {2{CPOL}};	// idle level, no edge out of reset
			sclk_prev <= CPOL;
			mosi_ff   <= 2'b00;
		end else begin
			cs_ff     <= {cs_ff[0], cs};
			cs_prev   <= cs_ff[1];
			sclk_ff   <= {sclk_ff[0], sclk};
			sclk_prev <= sclk_ff[1];
			mosi_ff   <= {mosi_ff[0], mosi};
		end
	end

	assign cs_sync    = cs_ff[1];
	assign mosi_sync  = mosi_ff[1];
	assign cs_fall    = cs_prev & ~cs_ff[1];	// frame start
	assign cs_rise    = ~cs_prev & cs_ff[1];	// frame end
	assign sclk_rise  = ~sclk_prev & sclk_ff[1];
	assign sclk_fall  = sclk_prev & ~sclk_ff[1];
	assign sclk_lead  = CPOL ? sclk_fall : sclk_rise;	// first edge leaving idle
	assign sclk_trail = CPOL ? sclk_rise : sclk_fall;	// back to idle level

	assign sample_pulse = CPHA ? sclk_trail : sclk_lead;	// edge the slave samples on

	a_lead_trail_excl: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!(sclk_lead && sclk_trail));

	// host must hold mosi across the sampling edge, same sync delay as sclk
	a_mosi_setup: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		sample_pulse && !cs_sync |-> $stable(mosi_sync));

endmodule

//--- spi_reg_bridge.f
spi_reg_pkg.sv
spi_edge_sync.sv
spi_slave.sv
spi_cmd_decoder.sv
spi_reg_file.sv
spi_reg_bridge.sv
tb_spi_reg_bridge.sv

//--- spi_reg_bridge.sv
// spi controlled register bank, top level
// synchronizer, byte slave, frame decoder and apb register file
`timescale 1ns/1ps

module spi_reg_bridge #(
	parameter bit CPOL     = 1'b1,	// spi mode 3 by default
	parameter bit CPHA     = 1'b1,
	parameter int NUM_REGS = spi_reg_pkg::num_regs
) (
	input  logic                            sys_clk,
	input  logic                            sys_rst_n,
	input  logic                            cs,	// active low
	input  logic                            sclk,
	input  logic                            mosi,
	output logic                            miso,
	input  logic                            psel,
	input  logic                            penable,
	input  logic                            pwrite,
	input  logic [spi_reg_pkg::paddr_w-1:0] paddr,
	input  logic [spi_reg_pkg::byte_w-1:0]  pwdata,
	output logic [spi_reg_pkg::byte_w-1:0]  prdata,
	output logic                            pready,
	output logic                            pslverr
);

	logic                           cs_sync;
	logic                           cs_fall;
	logic                           sclk_lead;
	logic                           sclk_trail;
	logic                           mosi_sync;
	logic                           byte_ack;
	logic [spi_reg_pkg::byte_w-1:0] rx_byte;
	logic [spi_reg_pkg::byte_w-1:0] tx_byte;
	logic                           spi_we;
	logic [spi_reg_pkg::addr_w-1:0] spi_addr;
	logic [spi_reg_pkg::byte_w-1:0] spi_wdata;
	logic [spi_reg_pkg::byte_w-1:0] spi_rdata;

	spi_edge_sync #(.CPOL(CPOL), .CPHA(CPHA)) u_edge_sync (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.cs         (cs),
		.sclk       (sclk),
		.mosi       (mosi),
		.cs_sync    (cs_sync),
		.cs_fall    (cs_fall),
		.cs_rise    (),	// frame end not needed, cs_sync aborts the fsm
		.sclk_lead  (sclk_lead),
		.sclk_trail (sclk_trail),
		.mosi_sync  (mosi_sync)
	);

	spi_slave #(.CPOL(CPOL), .CPHA(CPHA)) u_slave (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.cs_sync    (cs_sync),
		.sclk_lead  (sclk_lead),
		.sclk_trail (sclk_trail),
		.mosi_sync  (mosi_sync),
		.tx_byte    (tx_byte),
		.miso       (miso),
		.byte_ack   (byte_ack),
		.rx_byte    (rx_byte)
	);

	spi_cmd_decoder #(.NUM_REGS(NUM_REGS)) u_cmd_decoder (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.cs_fall    (cs_fall),
		.byte_ack   (byte_ack),
		.rx_byte    (rx_byte),
		.spi_rdata  (spi_rdata),
		.tx_byte    (tx_byte),
		.spi_we     (spi_we),
		.spi_addr   (spi_addr),
		.spi_wdata  (spi_wdata)
	);

	spi_reg_file #(.NUM_REGS(NUM_REGS)) u_reg_file (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.spi_we     (spi_we),
		.spi_addr   (spi_addr),
		.spi_wdata  (spi_wdata),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.spi_rdata  (spi_rdata)
	);

endmodule

//--- spi_reg_file.sv
// register bank shared by spi and apb
// zero wait apb slave, spi write/read port, apb wins same-cycle collisions
`timescale 1ns/1ps

module spi_reg_file #(
	parameter int NUM_REGS = spi_reg_pkg::num_regs
) (
	input  logic                            sys_clk,
	input  logic                            sys_rst_n,
	input  logic                            psel,
	input  logic                            penable,
	input  logic                            pwrite,
	input  logic [spi_reg_pkg::paddr_w-1:0] paddr,
	input  logic [spi_reg_pkg::byte_w-1:0]  pwdata,
	input  logic                            spi_we,
	input  logic [spi_reg_pkg::addr_w-1:0]  spi_addr,
	input  logic [spi_reg_pkg::byte_w-1:0]  spi_wdata,
	output logic [spi_reg_pkg::byte_w-1:0]  prdata,
	output logic                            pready,
	output logic                            pslverr,
	output logic [spi_reg_pkg::byte_w-1:0]  spi_rdata
);

	localparam int idx_w = $clog2(NUM_REGS);	// bits needed to index the bank

	logic [spi_reg_pkg::byte_w-1:0] regs [NUM_REGS];
	logic [idx_w-1:0]               apb_idx;
	logic [idx_w-1:0]               spi_idx;
	logic                           apb_hit;	// paddr inside the bank
	logic                           spi_hit;
	logic                           apb_access;	// second apb phase
	logic                           apb_wr;

	assign apb_idx    = paddr[idx_w-1:0];
	assign spi_idx    = spi_addr[idx_w-1:0];
	assign apb_hit    = int'(paddr) < NUM_REGS;
	assign spi_hit    = int'(spi_addr) < NUM_REGS;
	assign apb_access = psel && penable;
	assign apb_wr     = apb_access && pwrite && apb_hit;	// out of range writes dropped

	assign pready  = 1'b1;	// zero wait
	assign pslverr = apb_access && !apb_hit;
	assign prdata  = (psel && apb_hit) ? regs[apb_idx] : '0;
	assign spi_rdata = spi_hit ? regs[spi_idx] : '0;

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else begin
			if (spi_we && spi_hit)
				regs[spi_idx] <= spi_wdata;
			if (apb_wr)
				regs[apb_idx] <= pwdata;	// last assignment, apb wins
		end
	end

	// error response only in an access phase that followed a setup phase
	a_slverr_access: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		pslverr |-> apb_access && $past(psel && !penable));

endmodule

//--- spi_reg_pkg.sv
// shared constants for the spi register bank
// byte and address widths, register count, command bit, apb address width
package spi_reg_pkg;

	// spi side
	parameter int byte_w       = 8;	// one spi byte, one register
	parameter int addr_w       = 7;	// address field of the command byte
	parameter int cmd_read_bit = 7;	// 1 = read frame, 0 = write frame

	// register bank
	parameter int num_regs     = 16;	// default bank depth

	// apb side
	parameter int paddr_w      = 8;	// byte addressed, one reg per address

endpackage

//--- spi_slave.sv
// byte level spi slave
// six state edge counting fsm, mosi/miso shift registers, per byte ack
`timescale 1ns/1ps

module spi_slave #(
	parameter bit CPOL = 1'b1,	// sclk idle level
	parameter bit CPHA = 1'b1	// 1 = sample on trailing edge
) (
	input  logic                            sys_clk,
	input  logic                            sys_rst_n,
	input  logic                            cs_sync,	// active low, synchronized
	input  logic                            sclk_lead,
	input  logic                            sclk_trail,
	input  logic                            mosi_sync,
	input  logic [spi_reg_pkg::byte_w-1:0]  tx_byte,	// next byte to send
	output logic                            miso,
	output logic                            byte_ack,	// one cycle, byte done
	output logic [spi_reg_pkg::byte_w-1:0]  rx_byte
);

	typedef enum logic [2:0] {
		st_idle,	// reload tx, clear counters
		st_sclk_wait,	// wait for next phase edge
		st_sclk_edge,	// count the edge
		st_last_half,	// byte complete, settle
		st_ack,	// byte_ack high
		st_finish	// back to idle
	} state_t;

	state_t                           state;
	logic [4:0]                       edge_cnt;	// 16 phase edges per byte
	logic [spi_reg_pkg::byte_w-1:0]   mosi_shift;
	logic [spi_reg_pkg::byte_w-1:0]   miso_shift;
	logic                             edge_hit;	// expected edge seen while waiting
	logic                             even_edge;
	logic                             do_sample;
	logic                             do_shift;

	// even counts wait for the leading edge, odd counts for the trailing one
	assign edge_hit  = (state == st_sclk_wait) &&
		((!edge_cnt[0] && sclk_lead) || (edge_cnt[0] && sclk_trail));
	assign even_edge = !edge_cnt[0];

	// cpha 0 samples on even edges, cpha 1 on odd edges
	assign do_sample = edge_hit && (CPHA ? !even_edge : even_edge);
	// first even edge in cpha 1 only presents bit 7, no shift yet
	assign do_shift  = edge_hit && (CPHA ? (even_edge && edge_cnt != 5'd0) : !even_edge);

	assign miso     = miso_shift[spi_reg_pkg::byte_w-1];	// msb first
	assign rx_byte  = mosi_shift;
	assign byte_ack = (state == st_ack);

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			state <= st_idle;
		else if (cs_sync)
			state <= st_idle;	// cs high aborts from anywhere
		else begin
			case (state)
				st_idle:
					state <= st_sclk_wait;
				st_sclk_wait:
					if (edge_hit)
						state <= st_sclk_edge;
				st_sclk_edge:
					if (edge_cnt == 5'd15)
						state <= st_last_half;
					else
						state <= st_sclk_wait;
				st_last_half:
					state <= st_ack;
				st_ack:
					state <= st_finish;
				st_finish:
					state <= st_idle;
				default:
					state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			edge_cnt <= '0;
		else if (state == st_idle)
			edge_cnt <= '0;
		else if (state == st_sclk_edge && edge_cnt != 5'd15)
			edge_cnt <= edge_cnt + 5'd1;	// holds at 15 until idle
	end

	// miso side, reload at idle, shift on the change edge
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			miso_shift <= '0;	// miso low out of reset
		else if (state == st_idle && !cs_sync)
			miso_shift <= tx_byte;
		else if (do_shift)
			miso_shift <= {miso_shift[spi_reg_pkg::byte_w-2:0], 1'b0};
	end

	// mosi side
	always_ff @(posedge sys_clk) begin
		if (state == st_idle && !cs_sync)
			mosi_shift <= '0;
		else if (do_sample)
			mosi_shift <= {mosi_shift[spi_reg_pkg::byte_w-2:0], mosi_sync};
	end

	a_ack_single: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		byte_ack |=> !byte_ack);

	a_edge_cnt_max: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		edge_cnt <= 5'd15);

endmodule

//--- tb_spi_reg_bridge.sv
// testbench for the spi register bank
// spi host and apb host models, frame table, shadow registers, checks
`timescale 1ns/1ps

module tb_spi_reg_bridge;

	localparam bit CPOL      = 1'b1;	// spi mode 3
	localparam bit CPHA      = 1'b1;
	localparam int NUM_REGS  = spi_reg_pkg::num_regs;
	localparam int half_cyc  = 4;	// sclk half period in sys_clk cycles
	localparam int gap_cyc   = 8;	// idle after each byte and after cs rise
	localparam int lead_cyc  = 4;	// cs low to first sclk edge
	localparam int frame_cyc = lead_cyc + 2 * (16 * half_cyc + gap_cyc) + gap_cyc;

	localparam int src_spi = 0;
	localparam int src_apb = 1;
	localparam int op_idle = 0;	// miso level with cs high
	localparam int op_wr   = 1;
	localparam int op_rd   = 2;
	localparam int op_chk  = 3;	// apb read of the whole bank vs shadow
	localparam int op_fill = 4;	// random spi fill, spi readback
	localparam int op_cut  = 5;	// command byte only, then cs high

	logic                            sys_clk = 1'b0;
	logic                            sys_rst_n;
	logic                            cs;
	logic                            sclk;
	logic                            mosi;
	logic                            miso;
	logic                            psel;
	logic                            penable;
	logic                            pwrite;
	logic [spi_reg_pkg::paddr_w-1:0] paddr;
	logic [spi_reg_pkg::byte_w-1:0]  pwdata;
	logic [spi_reg_pkg::byte_w-1:0]  prdata;
	logic                            pready;
	logic                            pslverr;

	string      tbl_name[$];	// frame table, one entry per row
	int         tbl_src[$];
	int         tbl_op[$];
	int         tbl_addr[$];
	int         tbl_data[$];
	int         tbl_exp[$];	// -1 = predicted from shadow
	logic [7:0] shadow [NUM_REGS];
	logic [15:0] lfsr = 16'd55891;
	int         err_cnt = 0;
	int         chk_cnt = 0;
	int         fail_tests = 0;
	int         cycle_cnt = 0;
	int         cycle_limit = 0;

	spi_reg_bridge #(.CPOL(CPOL), .CPHA(CPHA), .NUM_REGS(NUM_REGS)) DUT (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
		.cs(cs), .sclk(sclk), .mosi(mosi), .miso(miso),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
	);

	always #2 sys_clk = ~sys_clk;	// 4 ns period

	always @(posedge sys_clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
			$display("timeout, run still busy after %0d cycles", cycle_cnt);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge sys_clk);
		#1;	// drive just after the edge
	endtask

	task automatic check_value(input string name, input int exp, input int act);
		chk_cnt++;
		if (exp != act) begin
			err_cnt++;
			$display("MISMATCH %s expected 0x%0h actual 0x%0h", name, exp, act);
		end
	endtask

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};	// x^16+x^14+x^13+x^11+1
	endfunction

	task automatic rand_byte(output logic [7:0] b);
		b = '0;
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_next(lfsr);	// one step per bit
			b = {b[6:0], lfsr[0]};
		end
	endtask

	// msb first, mosi changes and miso is sampled on the edges of the mode
	task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
		rx = '0;
		for (int i = 7; i >= 0; i--) begin
			if (!CPHA)
				mosi = tx[i];	// valid before leading edge
			wait_cycles(half_cyc);
			sclk = ~CPOL;	// leading edge
			if (CPHA)
				mosi = tx[i];
			else
				rx[i] = miso;
			wait_cycles(half_cyc);
			sclk = CPOL;	// trailing edge
			if (CPHA)
				rx[i] = miso;
		end
	endtask

	task automatic spi_frame(input logic [7:0] cmd, input logic [7:0] data, input bit full,
		output logic [7:0] rd);
		logic [7:0] dummy;
		cs = 1'b0;
		wait_cycles(lead_cyc);
		spi_byte(cmd, dummy);
		wait_cycles(gap_cyc);	// slave acks and reloads miso
		rd = '0;
		if (full) begin
			spi_byte(data, rd);
			wait_cycles(gap_cyc);	// ack and write before cs rises
		end
		cs = 1'b1;
		wait_cycles(gap_cyc);
	endtask

	task automatic spi_write(input int addr, input logic [7:0] data);
		logic [7:0] rd;
		spi_frame({1'b0, 7'(addr)}, data, 1'b1, rd);
		if (addr < NUM_REGS)
			shadow[addr] = data;	// out of range writes dropped
	endtask

	// setup cycle, access cycle, sample mid access cycle
	task automatic apb_xfer(input string name, input bit wr, input int addr,
		input logic [7:0] wdata, output logic [7:0] rdata, output logic err);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = 8'(addr);
		pwdata  = wdata;
		wait_cycles(1);
		penable = 1'b1;
		#2;
		rdata = prdata;
		err   = pslverr;
		check_value($sformatf("%s.pready", name), 1, int'(pready));	// zero wait slave
		wait_cycles(1);	// write commits on this edge
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic add_row(input string name, input int src, input int op, input int addr,
		input int data, input int exp);
		tbl_name.push_back(name);
		tbl_src.push_back(src);
		tbl_op.push_back(op);
		tbl_addr.push_back(addr);
		tbl_data.push_back(data);
		tbl_exp.push_back(exp);
	endtask

	task automatic build_table();
		add_row("reset_miso_idle", src_spi, op_idle, 0, 0, 0);
		add_row("reset_apb_bank", src_apb, op_chk, 0, 0, -1);
		add_row("spi_wr_r3", src_spi, op_wr, 3, 'ha5, -1);
		add_row("apb_rd_r3", src_apb, op_rd, 3, 0, 'ha5);
		add_row("spi_wr_r15", src_spi, op_wr, 15, 'h3c, -1);
		add_row("apb_rd_r15", src_apb, op_rd, 15, 0, 'h3c);
		add_row("apb_wr_r7", src_apb, op_wr, 7, 'h5a, -1);
		add_row("spi_rd_r7", src_spi, op_rd, 7, 0, 'h5a);
		add_row("apb_wr_r0", src_apb, op_wr, 0, 'h81, -1);
		add_row("spi_rd_r0", src_spi, op_rd, 0, 0, 'h81);
		add_row("spi_wr_oor", src_spi, op_wr, 'h13, 'hee, -1);	// aliases r3 if decode is wrong
		add_row("bank_after_oor", src_apb, op_chk, 0, 0, -1);
		add_row("spi_rd_oor", src_spi, op_rd, 'h13, 0, 0);
		add_row("apb_wr_oor", src_apb, op_wr, 'h10, 'h77, -1);
		add_row("apb_rd_oor", src_apb, op_rd, 'h10, 0, 0);
		add_row("apb_rd_oor_top", src_apb, op_rd, 'hff, 0, 0);
		add_row("spi_rand_fill", src_spi, op_fill, 0, 0, -1);
		add_row("spi_cut_r5", src_spi, op_cut, 5, 'h99, -1);
		add_row("apb_rd_r5_kept", src_apb, op_rd, 5, 0, -1);
		add_row("spi_wr_r5", src_spi, op_wr, 5, 'h66, -1);
		add_row("spi_rd_r5", src_spi, op_rd, 5, 0, 'h66);
		add_row("bank_final", src_apb, op_chk, 0, 0, -1);
	endtask

	task automatic run_row(input int t);
		logic [7:0] rd;
		logic [7:0] d;
		logic       err;
		int         addr;
		int         exp_val;
		addr = tbl_addr[t];
		case (tbl_op[t])
			op_idle:
				check_value(tbl_name[t], tbl_exp[t], int'(miso));
			op_wr: begin
				if (tbl_src[t] == src_spi)
					spi_write(addr, 8'(tbl_data[t]));
				else begin
					apb_xfer(tbl_name[t], 1'b1, addr, 8'(tbl_data[t]), rd, err);
					check_value($sformatf("%s.pslverr", tbl_name[t]), int'(addr >= NUM_REGS),
						int'(err));
					if (addr < NUM_REGS)
						shadow[addr] = 8'(tbl_data[t]);
				end
			end
			op_rd: begin
				exp_val = (addr < NUM_REGS) ? int'(shadow[addr]) : 0;	// range rule
				if (tbl_exp[t] >= 0)
					exp_val = tbl_exp[t];
				if (tbl_src[t] == src_spi)
					spi_frame({1'b1, 7'(addr)}, 8'h00, 1'b1, rd);
				else begin
					apb_xfer(tbl_name[t], 1'b0, addr, 8'h00, rd, err);
					check_value($sformatf("%s.pslverr", tbl_name[t]), int'(addr >= NUM_REGS),
						int'(err));
				end
				check_value(tbl_name[t], exp_val, int'(rd));
			end
			op_chk:
				for (int r = 0; r < NUM_REGS; r++) begin
					apb_xfer($sformatf("%s[%0d]", tbl_name[t], r), 1'b0, r, 8'h00, rd, err);
					check_value($sformatf("%s.pslverr[%0d]", tbl_name[t], r), 0, int'(err));
					check_value($sformatf("%s[%0d]", tbl_name[t], r), int'(shadow[r]), int'(rd));
				end
			op_fill: begin
				for (int r = 0; r < NUM_REGS; r++) begin
					rand_byte(d);
					spi_write(r, d);
				end
				for (int r = 0; r < NUM_REGS; r++) begin
					spi_frame({1'b1, 7'(r)}, 8'h00, 1'b1, rd);
					check_value($sformatf("%s[%0d]", tbl_name[t], r), int'(shadow[r]), int'(rd));
				end
			end
			op_cut:
				spi_frame({1'b0, 7'(addr)}, 8'(tbl_data[t]), 1'b0, rd);	// no data byte
			default: begin
				err_cnt++;
				$display("table row %0d holds an unknown operation %0d", t, tbl_op[t]);
			end
		endcase
	endtask

	initial begin
		int weight;
		int errs_before;
		sys_rst_n = 1'b0;
		cs        = 1'b1;
		sclk      = CPOL;
		mosi      = 1'b0;
		psel      = 1'b0;
		penable   = 1'b0;
		pwrite    = 1'b0;
		paddr     = '0;
		pwdata    = '0;
		for (int r = 0; r < NUM_REGS; r++)
			shadow[r] = '0;	// bank clears on reset
		build_table();
		weight = 0;
		foreach (tbl_op[t])
			weight += (tbl_op[t] == op_fill) ? 2 * NUM_REGS : 1;
		cycle_limit = (weight * frame_cyc * 5) / 2;
		repeat (3) @(posedge sys_clk);
		#1;
		sys_rst_n = 1'b1;
		wait_cycles(2);
		for (int t = 0; t < tbl_op.size(); t++) begin
			errs_before = err_cnt;
			run_row(t);
			if (err_cnt == errs_before)
				$display("test %s ok", tbl_name[t]);
			else begin
				fail_tests++;
				$display("test %s failed with %0d bad checks", tbl_name[t], err_cnt - errs_before);
			end
		end
		$display("%0d tests, %0d failed, %0d checks, %0d bad", tbl_op.size(), fail_tests,
			chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule
